// ==== vlog.f ====
+incdir+src
src/psramPkg.sv
src/psramCmdDecode.sv
src/psramBusExecute.sv
src/spramWordFetch.sv
src/psramLineTracker.sv
src/psramWriterTop.sv
tests/tbPsramWriter.sv

// ==== Bender.yml ====
package:
  name: psram_writer

sources:
  - include_dirs:
      - src
    files:
      - src/psramPkg.sv
      - src/psramCmdDecode.sv
      - src/psramBusExecute.sv
      - src/spramWordFetch.sv
      - src/psramLineTracker.sv
      - src/psramWriterTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/tbPsramWriter.sv

// ==== tests/tbPsramWriter.sv ====
`timescale 1ns/1ns
`include "psram_params.svh"

module tbPsramWriter;
    import psramPkg::*;

    localparam int LINE_WORDS      = `PSRAM_LINE_BYTES / 2;
    localparam int WORDS_PER_BURST = `PSRAM_BURST_BYTES / 2;
    localparam int BURSTS_PER_LINE = `PSRAM_LINE_BYTES / `PSRAM_BURST_BYTES;
    localparam int DATA_EDGE       = 6 + 2 * `PSRAM_LATENCY_CLOCKS;   // First data byte.
    localparam int INIT_TIMEOUT    = 2000;
    localparam int LINE_TIMEOUT    = 5000;

    logic                     iClk;
    logic                     iRst_N;
    logic                     iEn;
    logic                     iCapFrameStart;
    logic                     iCapLineDone;
    logic [1:0]               iRamDataValid;
    logic [15:0]              rdData;
    logic [`SPRAM_ADDR_W-1:0] rdAddr;
    logic                     rdEn;
    psramPins_t               ramPins;
    logic                     initDone;
    logic                     wrLineDone;
    logic                     wrFrameDone;

    logic [31:0] lfsrState;
    logic [15:0] lineBuf [LINE_WORDS];             // Line buffer model.
    logic [15:0] rdPipe;                           // First read latency stage.
    logic [7:0]  mrAddrTab [4] = '{`PSRAM_MR_ADDR_0, `PSRAM_MR_ADDR_1,
                                   `PSRAM_MR_ADDR_2, `PSRAM_MR_ADDR_3};
    logic [7:0]  mrDataTab [4] = '{`PSRAM_MR_DATA_0, `PSRAM_MR_DATA_1,
                                   `PSRAM_MR_DATA_2, `PSRAM_MR_DATA_3};
    logic [7:0]  winBytes [$];                     // Bytes of the open CE window.
    logic        prevClk;
    logic        prevCe;
    logic        rstSeen;
    logic        initSeen;
    logic        frameSeen;
    int          windowCount;                      // Closed windows, MR ones too.
    int          burstCount;
    int          gapCnt;                           // CE high cycles since last window.
    int          dataBytes;
    int          lineCount;
    int          linesGranted;                     // Capture lines offered with 11.

    always #5 iClk = ~iClk;

    psramWriterTop i_dut (
        .iClk           (iClk),
        .iRst_N         (iRst_N),
        .iEn            (iEn),
        .iCapFrameStart (iCapFrameStart),
        .iCapLineDone   (iCapLineDone),
        .iRamDataValid  (iRamDataValid),
        .rdData         (rdData),
        .rdAddr         (rdAddr),
        .rdEn           (rdEn),
        .ramPins        (ramPins),
        .initDone       (initDone),
        .wrLineDone     (wrLineDone),
        .wrFrameDone    (wrFrameDone)
    );

    //////////////////////////////////////////////////
    // Helpers.
    task automatic abortRun(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "Run stopped at the first failure.");
    endtask

    task automatic expectEq(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else abortRun($sformatf("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp));
    endtask

    function automatic logic [31:0] galoisStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            v         = {v[30:0], lfsrState[0]};   // One step per bit.
            lfsrState = galoisStep(lfsrState);
        end
        return v;
    endfunction

    task automatic fillLineBuffer();
        logic [31:0] bits;
        int i;
        for (i = 0; i < LINE_WORDS; i++)
        begin
            bits = takeBits(16);
            lineBuf[i] <= bits[15:0];
        end
    endtask

    // Two cycles of read latency, address taken every cycle.
    always @(posedge iClk)
    begin
        rdPipe <= (rdAddr < LINE_WORDS) ? lineBuf[rdAddr] : 16'h0000;
        rdData <= rdPipe;
    end

    //////////////////////////////////////////////////
    // Pin monitor and window checks.
    task automatic openWindow();
        if (windowCount > 0)
            assert (gapCnt >= `PSRAM_CE_GAP_CYCLES)
            else abortRun($sformatf("ERR %0t: CE high for only %0d cycles", $time, gapCnt));
        assert (rstSeen && ramPins.rst)
        else abortRun($sformatf("ERR %0t: window opened before the reset pulse", $time));
        assert (!frameSeen)
        else abortRun($sformatf("ERR %0t: window opened after frame done", $time));
        if (windowCount >= `PSRAM_MR_COUNT)        // Line windows need a valid line.
            assert (linesGranted > lineCount)
            else abortRun($sformatf("ERR %0t: line window without a capture line", $time));
        winBytes.delete();
    endtask

    task automatic closeWindow();
        logic [31:0] addr;
        int i;
        int wIdx;
        if (windowCount < `PSRAM_MR_COUNT)
        begin
            expectEq("MR window length", winBytes.size(), 8);
            expectEq("MR command 0", winBytes[0], `PSRAM_CMD_MODE_WR);
            expectEq("MR command 1", winBytes[1], `PSRAM_CMD_MODE_WR);
            for (i = 2; i < 5; i++)
                expectEq($sformatf("MR address byte %0d", i), winBytes[i], 8'h00);
            expectEq("MR register", winBytes[5], mrAddrTab[windowCount]);
            expectEq("MR data 0", winBytes[6], mrDataTab[windowCount]);
            expectEq("MR data 1", winBytes[7], mrDataTab[windowCount]);
            expectEq("initDone during config", initDone, 1'b0);
        end
        else
        begin
            addr = burstCount * `PSRAM_BURST_BYTES;
            expectEq("burst window length", winBytes.size(), DATA_EDGE + `PSRAM_BURST_BYTES);
            expectEq("burst command 0", winBytes[0], `PSRAM_CMD_BURST_WR);
            expectEq("burst command 1", winBytes[1], `PSRAM_CMD_BURST_WR);
            for (i = 0; i < 4; i++)                // MSB first.
                expectEq($sformatf("burst %0d address byte %0d", burstCount, i),
                         winBytes[2 + i], addr[31 - 8 * i -: 8]);
            for (i = 0; i < `PSRAM_BURST_BYTES; i++)
            begin
                wIdx = (burstCount % BURSTS_PER_LINE) * WORDS_PER_BURST + i / 2;
                expectEq($sformatf("burst %0d data byte %0d", burstCount, i),
                         winBytes[DATA_EDGE + i],
                         (i % 2) ? lineBuf[wIdx][7:0] : lineBuf[wIdx][15:8]);
            end
            burstCount++;
            dataBytes += `PSRAM_BURST_BYTES;
        end
        windowCount++;
        gapCnt = 0;
    endtask

    always @(negedge iClk)
    begin
        if (iRst_N)
        begin
            if (!ramPins.rst)
                rstSeen = 1'b1;
            if (prevCe && !ramPins.ce)
                openWindow();
            else if (!prevCe && ramPins.ce)
                closeWindow();
            else if (!ramPins.ce && ramPins.clk != prevClk)
            begin
                winBytes.push_back(ramPins.adq);  // Byte was set before the edge.
                if (windowCount >= `PSRAM_MR_COUNT && winBytes.size() > DATA_EDGE)
                    expectEq("rdEn on a data byte", rdEn, 1'b0);   // Low selects a read.
            end
            if (ramPins.ce)
                gapCnt++;
            if (wrLineDone)
            begin
                lineCount++;
                expectEq("data bytes at line done", dataBytes, lineCount * `PSRAM_LINE_BYTES);
            end
            if (wrFrameDone && !frameSeen)
            begin
                frameSeen = 1'b1;
                expectEq("lines at frame done", lineCount, `PSRAM_LINES_PER_FRAME);
            end
            if (initDone && !initSeen)
            begin
                initSeen = 1'b1;
                expectEq("windows before initDone", windowCount, `PSRAM_MR_COUNT);
            end
            prevClk = ramPins.clk;
            prevCe  = ramPins.ce;
        end
    end

    a_dqsLow: assert property (@(posedge iClk) disable iff (!iRst_N) !ramPins.dqs)
        else abortRun($sformatf("ERR %0t: DQS driven high", $time));

    a_rstWithCeHigh: assert property (@(posedge iClk) disable iff (!iRst_N)
        !ramPins.rst |-> ramPins.ce)
        else abortRun($sformatf("ERR %0t: PSRAM reset low with CE low", $time));

    a_lineDonePulse: assert property (@(posedge iClk) disable iff (!iRst_N)
        wrLineDone && iEn |=> !wrLineDone)
        else abortRun($sformatf("ERR %0t: wrLineDone longer than one cycle", $time));

    a_frameDoneHolds: assert property (@(posedge iClk) disable iff (!iRst_N)
        wrFrameDone |=> wrFrameDone)
        else abortRun($sformatf("ERR %0t: wrFrameDone dropped", $time));

    a_enableHold: assert property (@(posedge iClk) disable iff (!iRst_N)
        !iEn |=> $stable(ramPins) && $stable(initDone) && $stable(wrLineDone) &&
                 $stable(wrFrameDone) && $stable(rdAddr) && $stable(rdEn))
        else abortRun($sformatf("ERR %0t: outputs moved with iEn low", $time));

    //////////////////////////////////////////////////
    // Stimulus.
    task automatic idleCycles(input int n);
        repeat (n) @(posedge iClk);
    endtask

    task automatic offerLine(input logic [1:0] valid);
        @(posedge iClk);
        iRamDataValid <= valid;
        iCapLineDone  <= 1'b1;
        if (valid == 2'b11)
            linesGranted++;
        @(posedge iClk);
        iCapLineDone  <= 1'b0;
        iRamDataValid <= 2'b10;                    // Capture refills one half.
    endtask

    task automatic waitInit();
        int cnt;
        cnt = 0;
        while (!initDone && cnt < INIT_TIMEOUT)
        begin
            @(negedge iClk);
            cnt++;
        end
        if (!initDone)
            abortRun($sformatf("Timeout at %0t: initDone never rose.", $time));
    endtask

    task automatic waitLines(input int n);
        int cnt;
        cnt = 0;
        while (lineCount < n && cnt < LINE_TIMEOUT)
        begin
            @(posedge iClk);                       // Monitor counts settle at negedge.
            cnt++;
        end
        if (lineCount < n)
            abortRun($sformatf("Timeout at %0t: line %0d was never written.", $time, n));
    endtask

    task automatic holdEnable();
        int cnt;
        cnt = 0;
        while ((ramPins.ce || winBytes.size() <= DATA_EDGE + 2) && cnt < LINE_TIMEOUT)
        begin
            @(posedge iClk);                       // Window bytes settle at negedge.
            cnt++;
        end
        if (ramPins.ce || winBytes.size() <= DATA_EDGE + 2)
            abortRun($sformatf("Timeout at %0t: no burst reached its data bytes.", $time));
        @(posedge iClk);
        iEn <= 1'b0;                               // Freeze mid-burst.
        idleCycles(6);
        iEn <= 1'b1;
    endtask

    initial
    begin
        int line;
        iClk           = 1'b0;
        iRst_N         = 1'b0;
        iEn            = 1'b1;
        iCapFrameStart = 1'b0;
        iCapLineDone   = 1'b0;
        iRamDataValid  = 2'b00;
        rdData         = 16'h0000;
        rdPipe         = 16'h0000;
        lfsrState      = 32'h0ece0e0f;
        prevClk        = 1'b0;
        prevCe         = 1'b1;
        rstSeen        = 1'b0;
        initSeen       = 1'b0;
        frameSeen      = 1'b0;
        windowCount    = 0;
        burstCount     = 0;
        gapCnt         = 0;
        dataBytes      = 0;
        lineCount      = 0;
        linesGranted   = 0;
        fillLineBuffer();
        idleCycles(16);
        iRst_N <= 1'b1;
        @(negedge iClk);
        assert (ramPins.ce && ramPins.rst && !ramPins.clk && !ramPins.dqs &&
                !initDone && !wrLineDone && !wrFrameDone)
        else abortRun($sformatf("ERR %0t: wrong state after reset", $time));
        waitInit();
        @(posedge iClk);
        iCapFrameStart <= 1'b1;
        @(posedge iClk);
        iCapFrameStart <= 1'b0;
        for (line = 0; line < `PSRAM_LINES_PER_FRAME; line++)
        begin
            if (line > 0)
                fillLineBuffer();                  // New capture line in the buffer.
            @(posedge iClk);
            iRamDataValid <= 2'b11;                // Both halves valid, line not done yet.
            idleCycles(1 + takeBits(4));
            if (line < 2)
            begin
                offerLine((line == 0) ? 2'b01 : 2'b10);   // Half valid, must be ignored.
                idleCycles(40);
            end
            offerLine(2'b11);
            if (line == 1)
                holdEnable();
            waitLines(line + 1);
        end
        idleCycles(200);                           // Any window here is an error.
        if (lineCount == `PSRAM_LINES_PER_FRAME && frameSeen &&
            burstCount == `PSRAM_LINES_PER_FRAME * BURSTS_PER_LINE)
        begin
            $display(">>> PASS");
            $finish;
        end
        else
            abortRun($sformatf("Run ended with %0d lines and %0d bursts written.",
                               lineCount, burstCount));
    end

endmodule

// ==== src/psramWriterTop.sv ====
`timescale 1ns/1ns
`include "psram_params.svh"

module psramWriterTop (
    input  logic                     iClk,
    input  logic                     iRst_N,
    input  logic                     iEn,
    input  logic                     iCapFrameStart,
    input  logic                     iCapLineDone,
    input  logic [1:0]               iRamDataValid,
    input  logic [15:0]              rdData,
    output logic [`SPRAM_ADDR_W-1:0] rdAddr,
    output logic                     rdEn,
    output psramPkg::psramPins_t     ramPins,
    output logic                     initDone,
    output logic                     wrLineDone,
    output logic                     wrFrameDone
);
    import psramPkg::*;

    psramTxnLink_t txnLink;                        // Decoder request and descriptor.
    logic          txnAck;
    logic          wordReq;
    logic          wordAck;
    logic [15:0]   word;
    logic          burstDone;

    //////////////////////////////////////////////////
    // Transaction decode and pin execution.
    psramCmdDecode i_decode (
        .iClk           (iClk),
        .iRst_N         (iRst_N),
        .iEn            (iEn),
        .iCapFrameStart (iCapFrameStart),
        .iCapLineDone   (iCapLineDone),
        .iRamDataValid  (iRamDataValid),
        .lineDone       (wrLineDone),
        .frameDone      (wrFrameDone),
        .txnAck         (txnAck),
        .txnLink        (txnLink),
        .initDone       (initDone)
    );

    psramBusExecute i_execute (
        .iClk      (iClk),
        .iRst_N    (iRst_N),
        .iEn       (iEn),
        .txnLink   (txnLink),
        .txnAck    (txnAck),
        .wordReq   (wordReq),
        .wordAck   (wordAck),
        .word      (word),
        .burstDone (burstDone),
        .pins      (ramPins)
    );

    //////////////////////////////////////////////////
    // Line buffer reads and line/frame results.
    spramWordFetch i_fetch (
        .iClk     (iClk),
        .iRst_N   (iRst_N),
        .iEn      (iEn),
        .wordReq  (wordReq),
        .wordAck  (wordAck),
        .word     (word),
        .lineDone (wrLineDone),
        .rdAddr   (rdAddr),
        .rdEn     (rdEn),
        .rdData   (rdData)
    );

    psramLineTracker i_tracker (
        .iClk      (iClk),
        .iRst_N    (iRst_N),
        .iEn       (iEn),
        .burstDone (burstDone),
        .lineDone  (wrLineDone),
        .frameDone (wrFrameDone)
    );

endmodule

// ==== src/psramLineTracker.sv ====
`timescale 1ns/1ns
`include "psram_params.svh"

module psramLineTracker (
    input  logic iClk,
    input  logic iRst_N,
    input  logic iEn,
    input  logic burstDone,
    output logic lineDone,
    output logic frameDone
);

    localparam int BURSTS_PER_LINE = `PSRAM_LINE_BYTES / `PSRAM_BURST_BYTES;
    localparam int BURST_W         = $clog2(BURSTS_PER_LINE + 1);

    logic [BURST_W-1:0] burstCnt;                  // Bursts in the current line.
    logic [15:0]        lineCnt;                   // Lines in the frame.

    always_ff @(posedge iClk or negedge iRst_N)
    begin
        if (!iRst_N)
        begin
            burstCnt  <= '0;
            lineCnt   <= '0;
            lineDone  <= 1'b0;
            frameDone <= 1'b0;
        end
        else if (iEn)
        begin
            lineDone <= 1'b0;
            if (burstDone && !frameDone)
            begin
                if (burstCnt == BURST_W'(BURSTS_PER_LINE - 1))
                begin
                    burstCnt <= '0;
                    lineCnt  <= lineCnt + 16'd1;
                    lineDone <= 1'b1;
                    if (lineCnt == 16'(`PSRAM_LINES_PER_FRAME - 1))
                        frameDone <= 1'b1; // Stays high until reset.
                end
                else
                    burstCnt <= burstCnt + 1'b1;
            end
        end
    end

    a_linePulse: assert property (@(posedge iClk) disable iff (!iRst_N)
        lineDone && iEn |=> !lineDone)
        else $error("Line done held longer than one cycle.");

endmodule

// ==== src/spramWordFetch.sv ====
`timescale 1ns/1ns
`include "psram_params.svh"

module spramWordFetch (
    input  logic                     iClk,
    input  logic                     iRst_N,
    input  logic                     iEn,
    input  logic                     wordReq,
    output logic                     wordAck,
    output logic [15:0]              word,
    input  logic                     lineDone,
    output logic [`SPRAM_ADDR_W-1:0] rdAddr,
    output logic                     rdEn,
    input  logic [15:0]              rdData
);

    typedef enum logic [1:0] {F_IDLE, F_WAIT, F_CAP, F_ACK} fetchState_e;

    fetchState_e state;

    always_ff @(posedge iClk or negedge iRst_N)
    begin
        if (!iRst_N)
        begin
            state   <= F_IDLE;
            wordAck <= 1'b0;
            rdAddr  <= '0;
            rdEn    <= 1'b1;                       // 1 is write, 0 is read.
        end
        else if (iEn)
        begin
            case (state)
                F_IDLE:
                    if (wordReq && !wordAck)
                    begin
                        rdEn  <= 1'b0;             // Start the read.
                        state <= F_WAIT;
                    end
                F_WAIT:
                    state <= F_CAP;                // Second cycle of RAM latency.
                F_CAP:
                begin
                    word    <= rdData;
                    wordAck <= 1'b1;
                    state   <= F_ACK;
                end
                default:
                    if (!wordReq)
                    begin
                        wordAck <= 1'b0;
                        rdAddr  <= rdAddr + 1'b1;  // Next word of the line.
                        state   <= F_IDLE;
                    end
            endcase
            if (lineDone)
                rdAddr <= '0;                      // Each line starts at word 0.
        end
    end

endmodule

// ==== src/psramBusExecute.sv ====
`timescale 1ns/1ns
`include "psram_params.svh"

module psramBusExecute (
    input  logic                    iClk,
    input  logic                    iRst_N,
    input  logic                    iEn,
    input  psramPkg::psramTxnLink_t txnLink,
    output logic                    txnAck,
    output logic                    wordReq,
    input  logic                    wordAck,
    input  logic [15:0]             word,
    output logic                    burstDone,
    output psramPkg::psramPins_t    pins
);
    import psramPkg::*;

    localparam int DATA_EDGE  = 6 + 2 * `PSRAM_LATENCY_CLOCKS;   // First data edge.
    localparam int BURST_LAST = DATA_EDGE + `PSRAM_BURST_BYTES - 1;
    localparam int MODE_LAST  = 7;                               // Cmd, addr, data twice.

    typedef enum logic [2:0] {
        X_IDLE, X_RESET, X_SETUP, X_EDGE, X_FETCH, X_CLOSE, X_GAP, X_ACK
    } exeState_e;

    exeState_e   state;
    logic [15:0] cnt;                              // Reset and CE gap timer.
    logic [5:0]  edgeIdx;                          // PSRAM clock edge in the window.
    logic [5:0]  lastEdge;
    logic [15:0] wordBuf;                          // Word being sent.
    logic [7:0]  edgeByte;                         // Byte for the coming edge.
    logic        isBurst;

    assign isBurst  = txnLink.txn.kind == TXN_BURST_WR;
    assign lastEdge = isBurst ? 6'(BURST_LAST) : 6'(MODE_LAST);

    //////////////////////////////////////////////////
    // Byte presented before each edge.
    always_comb
    begin
        case (edgeIdx)
            6'd0, 6'd1: edgeByte = isBurst ? `PSRAM_CMD_BURST_WR : `PSRAM_CMD_MODE_WR;
            6'd2:       edgeByte = txnLink.txn.addr[31:24];  // Address, MSB first.
            6'd3:       edgeByte = txnLink.txn.addr[23:16];
            6'd4:       edgeByte = txnLink.txn.addr[15:8];
            6'd5:       edgeByte = txnLink.txn.addr[7:0];
            default:
                if (!isBurst)
                    edgeByte = txnLink.txn.mrData;
                else if (edgeIdx < 6'(DATA_EDGE))
                    edgeByte = 8'h00;                        // Latency dummies.
                else
                    edgeByte = edgeIdx[0] ? wordBuf[7:0] : wordBuf[15:8];
        endcase
    end

    //////////////////////////////////////////////////
    // Beat sequencer, two iClk cycles per PSRAM edge.
    always_ff @(posedge iClk or negedge iRst_N)
    begin
        if (!iRst_N)
        begin
            state     <= X_IDLE;
            cnt       <= '0;
            edgeIdx   <= '0;
            txnAck    <= 1'b0;
            wordReq   <= 1'b0;
            burstDone <= 1'b0;
            pins      <= '{clk: 1'b0, rst: 1'b1, ce: 1'b1, dqs: 1'b0, adq: 8'h00};
        end
        else if (iEn)
        begin
            case (state)
                X_IDLE:
                    if (txnLink.req && !txnAck)
                    begin
                        edgeIdx <= '0;
                        cnt     <= '0;
                        if (txnLink.txn.kind == TXN_DEV_RST)
                        begin
                            pins.rst <= 1'b0;      // CE stays high.
                            state    <= X_RESET;
                        end
                        else
                        begin
                            pins.ce <= 1'b0;       // Open the window.
                            state   <= X_SETUP;
                        end
                    end
                X_RESET:
                    if (!pins.rst)
                    begin
                        if (cnt == 16'(`PSRAM_RST_LOW_CYCLES - 1))
                        begin
                            pins.rst <= 1'b1;
                            cnt      <= '0;
                        end
                        else
                            cnt <= cnt + 16'd1;
                    end
                    else if (cnt == 16'(`PSRAM_RST_RECOVER_CYCLES - 1))
                    begin
                        txnAck <= 1'b1;
                        state  <= X_ACK;
                    end
                    else
                        cnt <= cnt + 16'd1;
                X_SETUP:
                begin
                    pins.adq <= edgeByte;
                    state    <= X_EDGE;
                end
                X_EDGE:
                begin
                    pins.clk <= ~pins.clk;
                    edgeIdx  <= edgeIdx + 6'd1;
                    if (edgeIdx == lastEdge)
                        state <= X_CLOSE;
                    else if (isBurst && edgeIdx >= 6'(DATA_EDGE - 1) && edgeIdx[0])
                        state <= X_FETCH;          // New word before each rising data edge.
                    else
                        state <= X_SETUP;
                end
                X_FETCH:                           // PSRAM clock holds while waiting.
                    if (!wordReq && !wordAck)
                        wordReq <= 1'b1;
                    else if (wordReq && wordAck)
                    begin
                        wordBuf <= word;
                        wordReq <= 1'b0;
                        state   <= X_SETUP;
                    end
                X_CLOSE:
                begin
                    pins.ce  <= 1'b1;
                    pins.adq <= 8'h00;
                    cnt      <= '0;
                    state    <= X_GAP;
                end
                X_GAP:
                    if (cnt == 16'(`PSRAM_CE_GAP_CYCLES - 1))
                    begin
                        txnAck    <= 1'b1;
                        burstDone <= isBurst;
                        state     <= X_ACK;
                    end
                    else
                        cnt <= cnt + 16'd1;
                default:                           // X_ACK.
                begin
                    burstDone <= 1'b0;
                    if (!txnLink.req)
                    begin
                        txnAck <= 1'b0;
                        state  <= X_IDLE;
                    end
                end
            endcase
        end
    end

    a_rstOutsideCe: assert property (@(posedge iClk) disable iff (!iRst_N)
        !pins.rst |-> pins.ce)
        else $error("PSRAM reset low inside a CE window.");

    a_clkIdle: assert property (@(posedge iClk) disable iff (!iRst_N)
        pins.ce |=> $stable(pins.clk))
        else $error("PSRAM clock toggled with CE high.");

endmodule

// ==== src/psramCmdDecode.sv ====
`timescale 1ns/1ns
`include "psram_params.svh"

module psramCmdDecode (
    input  logic                    iClk,
    input  logic                    iRst_N,
    input  logic                    iEn,
    input  logic                    iCapFrameStart,
    input  logic                    iCapLineDone,
    input  logic [1:0]              iRamDataValid,
    input  logic                    lineDone,
    input  logic                    frameDone,
    input  logic                    txnAck,
    output psramPkg::psramTxnLink_t txnLink,
    output logic                    initDone
);
    import psramPkg::*;

    typedef enum logic [2:0] {
        S_PWRUP, S_RESET, S_MODE, S_FRAME, S_LINE, S_BURST, S_STOP
    } decState_e;

    decState_e   state;
    logic [15:0] delayCnt;                         // Power-up wait.
    logic [1:0]  mrIdx;                            // Mode register table index.
    logic [31:0] burstAddr;                        // Next PSRAM burst address.
    logic [7:0]  mrAddr;
    logic [7:0]  mrData;
    psramTxn_t   nextTxn;
    logic        issue;                            // Link idle, a req may rise.
    logic        taken;                            // Executor finished the txn.

    always_comb
    begin
        case (mrIdx)
            2'd0:    {mrAddr, mrData} = {`PSRAM_MR_ADDR_0, `PSRAM_MR_DATA_0};
            2'd1:    {mrAddr, mrData} = {`PSRAM_MR_ADDR_1, `PSRAM_MR_DATA_1};
            2'd2:    {mrAddr, mrData} = {`PSRAM_MR_ADDR_2, `PSRAM_MR_DATA_2};
            default: {mrAddr, mrData} = {`PSRAM_MR_ADDR_3, `PSRAM_MR_DATA_3};
        endcase
    end

    always_comb
    begin
        nextTxn.kind   = TXN_BURST_WR;             // Line data by default.
        nextTxn.addr   = burstAddr;
        nextTxn.mrData = 8'h00;
        if (state == S_RESET)
            nextTxn.kind = TXN_DEV_RST;
        else if (state == S_MODE)
        begin
            nextTxn.kind   = TXN_MODE_WR;
            nextTxn.addr   = {24'h000000, mrAddr}; // Three zero bytes, then the register.
            nextTxn.mrData = mrData;
        end
    end

    assign issue = !txnLink.req && !txnAck;
    assign taken = txnLink.req && txnAck;

    always_ff @(posedge iClk or negedge iRst_N)
    begin
        if (!iRst_N)
        begin
            state     <= S_PWRUP;
            delayCnt  <= '0;
            mrIdx     <= '0;
            burstAddr <= '0;                       // Line data starts at PSRAM address 0.
            txnLink   <= '0;
            initDone  <= 1'b0;
        end
        else if (iEn)
        begin
            if (issue && (state == S_RESET || state == S_MODE ||
                (state == S_BURST && !lineDone && !frameDone)))
            begin
                txnLink.req <= 1'b1;
                txnLink.txn <= nextTxn;
            end
            if (taken)
                txnLink.req <= 1'b0;               // Second phase of the handshake.

            case (state)
                S_PWRUP:
                    if (delayCnt == 16'(`PSRAM_PWRUP_CYCLES - 1))
                        state <= S_RESET;
                    else
                        delayCnt <= delayCnt + 16'd1;
                S_RESET:
                    if (taken)
                        state <= S_MODE;
                S_MODE:
                    if (taken)
                    begin
                        if (mrIdx == 2'(`PSRAM_MR_COUNT - 1))
                        begin
                            initDone <= 1'b1;      // Capture may start now.
                            state    <= S_FRAME;
                        end
                        else
                            mrIdx <= mrIdx + 2'd1;
                    end
                S_FRAME:
                    if (iCapFrameStart)
                        state <= S_LINE;
                S_LINE:                            // Both buffer halves must be valid.
                    if (iCapLineDone && iRamDataValid == 2'b11)
                        state <= S_BURST;
                S_BURST:
                    if (frameDone)
                        state <= S_STOP;
                    else if (lineDone)
                        state <= S_LINE;
                    else if (taken)
                        burstAddr <= burstAddr + 32'(`PSRAM_BURST_BYTES);
                default: ;                         // Frame written, park here.
            endcase
        end
    end

    a_txnStable: assert property (@(posedge iClk) disable iff (!iRst_N)
        txnLink.req && !txnAck |=> $stable(txnLink.txn))
        else $error("Transaction descriptor changed while req was pending.");

endmodule

// ==== src/psramPkg.sv ====
package psramPkg;

    //////////////////////////////////////////////////
    // Transactions from the decoder to the executor.
    typedef enum logic [1:0] {
        TXN_DEV_RST  = 2'd0,                       // Reset pin pulse plus recovery.
        TXN_MODE_WR  = 2'd1,                       // One mode register write.
        TXN_BURST_WR = 2'd2                        // One linear burst of line data.
    } psramTxnKind_e;

    typedef struct packed {
        psramTxnKind_e kind;
        logic [31:0]   addr;                       // PSRAM byte address, or MR address.
        logic [7:0]    mrData;                     // Mode register value.
    } psramTxn_t;

    typedef struct packed {
        logic      req;                            // Four-phase request.
        psramTxn_t txn;                            // Stable while req is high.
    } psramTxnLink_t;

    //////////////////////////////////////////////////
    // Octal DDR PSRAM pins.
    typedef struct packed {
        logic       clk;
        logic       rst;                           // Active low device reset.
        logic       ce;                            // Active low chip enable.
        logic       dqs;                           // Write mask, held low.
        logic [7:0] adq;                           // Address, command and data.
    } psramPins_t;

endpackage

// ==== src/psram_params.svh ====
`ifndef PSRAM_PARAMS_SVH
`define PSRAM_PARAMS_SVH

//////////////////////////////////////////////////
// Power-up and reset timing, in iClk cycles.
`define PSRAM_PWRUP_CYCLES       20        // Device wait before reset, short for sim.
`define PSRAM_RST_LOW_CYCLES     4         // Reset pin low time.
`define PSRAM_RST_RECOVER_CYCLES 10        // Reset to first command.
`define PSRAM_CE_GAP_CYCLES      6         // Minimum CE high between windows.

//////////////////////////////////////////////////
// Burst geometry and frame size.
`define PSRAM_LATENCY_CLOCKS     4         // Dummy clocks between address and data.
`define PSRAM_BURST_BYTES        12        // CE low time is limited.
`define PSRAM_LINE_BYTES         48        // Multiple of the burst size.
`define PSRAM_LINES_PER_FRAME    3
`define SPRAM_ADDR_W             14        // Line buffer word address.

//////////////////////////////////////////////////
// Command bytes and the mode register table.
`define PSRAM_CMD_BURST_WR       8'hA0     // Linear burst write.
`define PSRAM_CMD_MODE_WR        8'hC0     // Mode register write.
`define PSRAM_MR_COUNT           4
`define PSRAM_MR_ADDR_0          8'h00     // Read latency, drive strength.
`define PSRAM_MR_DATA_0          8'h11
`define PSRAM_MR_ADDR_1          8'h04     // Write latency, refresh.
`define PSRAM_MR_DATA_1          8'h20
`define PSRAM_MR_ADDR_2          8'h08     // Burst type and length.
`define PSRAM_MR_DATA_2          8'h04
`define PSRAM_MR_ADDR_3          8'h06     // Half sleep off.
`define PSRAM_MR_DATA_3          8'h00

`endif
